//--- logic/booth_mul_top.sv
// takes one operation per cycle, result two edges later; no back-pressure, consumer must keep up
module booth_mul_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           mul_valid,
	input  logic           flush,
	input  logic           mulw,
	input  logic [1:0]     mul_signed,
	input  mul_pkg::xlen_t multiplicand,
	input  mul_pkg::xlen_t multiplier,
	output logic           out_valid,
	output mul_pkg::xlen_t result_hi,
	output mul_pkg::xlen_t result_lo
);

	mul_pkg::pp_array_t pp_rows;
	mul_pkg::pp_stage_t pp_in;
	mul_pkg::pp_stage_t pp_q;
	logic               pp_valid;
	mul_pkg::col_vec_t  wt_sum;
	mul_pkg::col_vec_t  wt_carry;
	mul_pkg::sc_stage_t sc_in;
	mul_pkg::sc_stage_t sc_q;
	logic               sc_valid;

	booth_pp_gen i_decode (
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.rows         (pp_rows)
	);

	assign pp_in = '{
		rows: pp_rows,
		mode: '{word: mulw, a_signed: mul_signed[0], b_signed: mul_signed[1]}
	};

	mul_stage_reg #(.payload_t(mul_pkg::pp_stage_t)) i_stage1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (mul_valid),
		.in_data   (pp_in),
		.out_valid (pp_valid),
		.out_data  (pp_q)
	);

	wallace_tree i_execute (
		.rows  (pp_q.rows),
		.sum   (wt_sum),
		.carry (wt_carry)
	);

	assign sc_in = '{sum: wt_sum, carry: wt_carry, mode: pp_q.mode};

	mul_stage_reg #(.payload_t(mul_pkg::sc_stage_t)) i_stage2 (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (pp_valid),
		.in_data   (sc_in),
		.out_valid (sc_valid),
		.out_data  (sc_q)
	);

	product_resolve i_result (
		.sc_valid  (sc_valid),
		.sc_data   (sc_q),
		.out_valid (out_valid),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

endmodule

//--- logic/booth_pp_gen.sv
// combinational radix-4 decode; in word mode the operands' upper halves are ignored
`include "mul_params.svh"

module booth_pp_gen (
	input  mul_pkg::xlen_t     multiplicand,
	input  mul_pkg::xlen_t     multiplier,
	input  logic               mulw,
	input  logic [1:0]         mul_signed,
	output mul_pkg::pp_array_t rows
);

	logic                  a_sign;
	logic                  b_sign;
	logic [`MUL_EXT_W-1:0] a_ext;
	logic [`MUL_EXT_W-1:0] b_ext;
	// multiplier with the implicit zero below bit 0
	logic [`MUL_EXT_W:0]   b_pad;

	// word ops take their sign from bit 31
	assign a_sign = mul_signed[0] & (mulw ? multiplicand[31] : multiplicand[`MUL_XLEN-1]);
	assign b_sign = mul_signed[1] & (mulw ? multiplier[31] : multiplier[`MUL_XLEN-1]);

	assign a_ext = mulw ? {{(`MUL_EXT_W-32){a_sign}}, multiplicand[31:0]}
	                    : {{(`MUL_EXT_W-`MUL_XLEN){a_sign}}, multiplicand};
	assign b_ext = mulw ? {{(`MUL_EXT_W-32){b_sign}}, multiplier[31:0]}
	                    : {{(`MUL_EXT_W-`MUL_XLEN){b_sign}}, multiplier};

	assign b_pad = {b_ext, 1'b0};

	always_comb begin
		logic [2:0]                    grp;
		logic [`MUL_PROD_W-1:0]        mcand;
		logic [`MUL_PROD_W-1:0]        mult;
		logic signed [`MUL_PROD_W-1:0] sig_top;
		mcand = {{(`MUL_PROD_W-`MUL_EXT_W){a_ext[`MUL_EXT_W-1]}}, a_ext};
		for (int i = 0; i < `MUL_ROWS; i++) begin
			grp = b_pad[2*i+2 -: 3];
			case (grp)
				3'b001, 3'b010: mult = mcand;
				3'b011:         mult = mcand << 1;
				3'b100:         mult = -(mcand << 1);
				3'b101, 3'b110: mult = -mcand;
				default:        mult = '0;
			endcase
			rows[i] = mult << (2 * i);

			// +-2a needs 67 bits, so everything above bit 66+2i must be pure sign
			sig_top = $signed(rows[i]) >>> (`MUL_EXT_W + 2 * i);
			if (!$isunknown(mult)) begin
				assert (sig_top == '0 || sig_top == '1)
					else $error("booth row %0d is wider than its significant width", i);
			end
		end
	end

endmodule

//--- logic/csa_column.sv
// one product column of the tree; carry_in must come from the column one bit lower
`include "mul_params.svh"

module csa_column (
	input  logic [`MUL_ROWS-1:0]      bits,
	input  logic [`MUL_CARRY_GRP-1:0] carry_in,
	output logic [`MUL_CARRY_GRP-1:0] carry_out,
	output logic                      sum_bit,
	output logic                      carry_bit
);

	localparam int LVLS   = 8;
	localparam int MAX_FA = `MUL_ROWS / 3;

	// bits entering each level, 33 down to 3
	localparam int LVL_IN [LVLS] = '{33, 22, 15, 10, 7, 5, 4, 3};

	function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
		logic s;
		logic co;
		s  = a ^ b ^ c;
		co = (a & b) | (a & c) | (b & c);
		return {co, s};
	endfunction

	// carries leave and enter in level order, so lane numbering matches on both sides
	always_comb begin
		logic [`MUL_ROWS-1:0] w;
		logic [`MUL_ROWS-1:0] nxt;
		logic [1:0]           fa;
		int                   base;
		int                   nfa;
		int                   keep;
		w         = bits;
		base      = 0;
		carry_out = '0;
		for (int l = 0; l < LVLS; l++) begin
			nfa  = LVL_IN[l] / 3;
			keep = LVL_IN[l] - 3 * nfa;
			nxt  = '0;
			for (int j = 0; j < MAX_FA; j++) begin
				if (j < nfa) begin
					fa                = full_add(w[3*j], w[3*j+1], w[3*j+2]);
					nxt[j]            = fa[0];
					carry_out[base+j] = fa[1];
				end
			end

			// at most two bits skip an adder on any level
			for (int j = 0; j < 2; j++) begin
				if (j < keep) begin
					nxt[nfa+j] = w[3*nfa+j];
				end
			end

			// lower column's carries from this same level
			for (int j = 0; j < MAX_FA; j++) begin
				if (j < nfa) begin
					nxt[nfa+keep+j] = carry_in[base+j];
				end
			end

			base += nfa;
			w     = nxt;
		end

		// both weigh this column; carry_bit is the lower column's last carry
		sum_bit   = w[0];
		carry_bit = w[1];
	end

endmodule

//--- logic/mul_params.svh
// fixed for RV64 with 32-bit word ops; changing a width means redoing the Booth row and tree shapes
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// operand and result word
`define MUL_XLEN 64

// two extra bits keep an unsigned operand positive under signed Booth recoding
`define MUL_EXT_W 66

// one radix-4 row per two multiplier bits of the extended operand
`define MUL_ROWS 33

// full signed product of two extended operands
`define MUL_PROD_W 132

// full adders per column, each sends its carry one column up
`define MUL_CARRY_GRP 31

`endif

//--- logic/mul_pkg.sv
// payload types for the pipelined Booth multiplier; widths come from mul_params.svh
`include "mul_params.svh"

package mul_pkg;

	// operand or one half of the product
	typedef logic [`MUL_XLEN-1:0] xlen_t;

	// one Booth multiple, already shifted and sign-extended to the product width
	typedef logic [`MUL_PROD_W-1:0] pp_row_t;

	typedef pp_row_t [`MUL_ROWS-1:0] pp_array_t;

	// sum or carry vector out of the compressor
	typedef logic [`MUL_PROD_W-1:0] col_vec_t;

	// only word is consumed after decode
	typedef struct packed {
		logic word;
		logic a_signed;
		logic b_signed;
	} mode_t;

	// stage 1, partial products
	typedef struct packed {
		pp_array_t rows;
		mode_t     mode;
	} pp_stage_t;

	// stage 2, redundant sum and carry form
	typedef struct packed {
		col_vec_t sum;
		col_vec_t carry;
		mode_t    mode;
	} sc_stage_t;

endpackage

//--- logic/mul_stage_reg.sv
// valid bit clears on reset or flush; payload is only meaningful while out_valid is high
module mul_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_data <= in_data;
		end
	end

	// nothing in flight may survive a flush
	a_flush_drains: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !out_valid)
		else $error("stage valid still high the cycle after flush");

endmodule

//--- logic/product_resolve.sv
// combinational final add; only the low 128 bits of the 132-bit sum are kept
`include "mul_params.svh"

module product_resolve (
	input  logic               sc_valid,
	input  mul_pkg::sc_stage_t sc_data,
	output logic               out_valid,
	output mul_pkg::xlen_t     result_hi,
	output mul_pkg::xlen_t     result_lo
);

	logic [2*`MUL_XLEN-1:0] prod;

	// carry bits weigh one column more than their index
	assign prod = sc_data.sum[2*`MUL_XLEN-1:0]
	            + {sc_data.carry[2*`MUL_XLEN-2:0], 1'b0};

	assign out_valid = sc_valid;
	assign result_hi = prod[2*`MUL_XLEN-1:`MUL_XLEN];

	// MULW returns the low word sign-extended
	assign result_lo = sc_data.mode.word ? {{(`MUL_XLEN-32){prod[31]}}, prod[31:0]}
	                                     : prod[`MUL_XLEN-1:0];

	// an X here means a stage captured without a valid operation behind it
	always_comb begin
		if (out_valid) begin
			assert (!$isunknown({result_hi, result_lo}))
				else $error("result carries unknown bits while out_valid is high");
		end
	end

endmodule

//--- logic/wallace_tree.sv
// combinational compressor; the product is kept modulo 2**132 only
`include "mul_params.svh"

module wallace_tree (
	input  mul_pkg::pp_array_t rows,
	output mul_pkg::col_vec_t  sum,
	output mul_pkg::col_vec_t  carry
);

	logic [`MUL_PROD_W-1:0][`MUL_ROWS-1:0] col_bits;
	logic [`MUL_PROD_W-1:0]                col_last;

	always_comb begin
		for (int k = 0; k < `MUL_PROD_W; k++) begin
			for (int r = 0; r < `MUL_ROWS; r++) begin
				col_bits[k][r] = rows[r][k];
			end
		end
	end

	for (genvar k = 0; k < `MUL_PROD_W; k++) begin : g_col
		logic [`MUL_CARRY_GRP-1:0] cin;
		logic [`MUL_CARRY_GRP-1:0] cout;

		if (k == 0) begin : g_first
			assign cin = '0;
		end else begin : g_link
			assign cin = g_col[k-1].cout;
		end

		csa_column i_col (
			.bits      (col_bits[k]),
			.carry_in  (cin),
			.carry_out (cout),
			.sum_bit   (sum[k]),
			.carry_bit (col_last[k])
		);
	end

	// realign so carry[k] weighs k+1; the top column's other carries fall off the end
	assign carry = {g_col[`MUL_PROD_W-1].cout[`MUL_CARRY_GRP-1], col_last[`MUL_PROD_W-1:1]};

endmodule

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the simulation's

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module tb_booth_mul \
	-o sim_tb_booth_mul
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status" >&2
	exit "$status"
fi

./obj_dir/sim_tb_booth_mul
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status" >&2
	exit "$status"
fi

exit 0

//--- sim.f
+incdir+logic
logic/mul_pkg.sv
logic/booth_pp_gen.sv
logic/csa_column.sv
logic/wallace_tree.sv
logic/mul_stage_reg.sv
logic/product_resolve.sv
logic/booth_mul_top.sv
testbench/tb_booth_mul.sv

//--- testbench/tb_booth_mul.sv
// each result is checked against a 128-bit model two edges after acceptance; first error stops
`include "mul_params.svh"

module tb_booth_mul;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_ROWS  = 40;
	localparam int MARGIN       = 30;
	localparam logic [31:0] SEED = 32'hd6a7_147d;
	localparam mul_pkg::xlen_t TOP_BIT = 64'h8000_0000_0000_0000;

	typedef struct packed {
		logic           mulw;
		logic [1:0]     sgn;
		mul_pkg::xlen_t a;
		mul_pkg::xlen_t b;
		logic           gap;
		logic           flush;
	} stim_t;

	typedef struct packed {
		mul_pkg::xlen_t hi;
		mul_pkg::xlen_t lo;
		int             due;
	} expect_t;

	logic           clk = 1'b0;
	logic           rst_n;
	logic           mul_valid;
	logic           flush;
	logic           mulw;
	logic [1:0]     mul_signed;
	mul_pkg::xlen_t multiplicand;
	mul_pkg::xlen_t multiplier;
	logic           out_valid;
	mul_pkg::xlen_t result_hi;
	mul_pkg::xlen_t result_lo;

	stim_t   table_q[$];
	expect_t exp_q[$];
	int      cyc = 0;
	int      cycle_limit = 0;

	booth_mul_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic report_mismatch(input string name, input mul_pkg::xlen_t got,
			input mul_pkg::xlen_t want);
		$display("CHECK FAILED at %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, want);
		abort_run("a result word differs from the reference product");
	endtask

	// operands are extended to 128 bits first, so the truncated product is exact
	function automatic logic [2*`MUL_XLEN-1:0] expected_product(input logic word,
			input logic [1:0] sgn, input mul_pkg::xlen_t a, input mul_pkg::xlen_t b);
		logic [2*`MUL_XLEN-1:0] a_wide;
		logic [2*`MUL_XLEN-1:0] b_wide;
		logic [2*`MUL_XLEN-1:0] prod;
		mul_pkg::xlen_t         lo;
		if (word) begin
			a_wide = sgn[0] ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
			b_wide = sgn[1] ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
		end else begin
			a_wide = sgn[0] ? {{64{a[63]}}, a} : {64'b0, a};
			b_wide = sgn[1] ? {{64{b[63]}}, b} : {64'b0, b};
		end
		prod = a_wide * b_wide;
		lo   = word ? {{32{prod[31]}}, prod[31:0]} : prod[63:0];
		return {prod[127:64], lo};
	endfunction

	// random value with a bias towards sign-boundary corners
	function automatic mul_pkg::xlen_t random_operand();
		mul_pkg::xlen_t v;
		v = {$urandom(), $urandom()};
		case ($urandom_range(7, 0))
			0: v = '1;
			1: v = TOP_BIT;
			2: v = {v[63:32], 32'h8000_0000};
			default: ;
		endcase
		return v;
	endfunction

	task automatic add_row(input logic word, input logic [1:0] sgn, input mul_pkg::xlen_t a,
			input mul_pkg::xlen_t b, input logic gap, input logic fl);
		stim_t s;
		s.mulw  = word;
		s.sgn   = sgn;
		s.a     = a;
		s.b     = b;
		s.gap   = gap;
		s.flush = fl;
		table_q.push_back(s);
	endtask

	task automatic build_table();
		logic           word;
		logic [1:0]     sgn;
		mul_pkg::xlen_t a;
		mul_pkg::xlen_t b;
		logic           gap;
		logic           fl;
		// full width corners, every signedness combination
		add_row(1'b0, 2'b00, '1, '1, 1'b0, 1'b0);
		add_row(1'b0, 2'b11, '1, '1, 1'b0, 1'b0);
		add_row(1'b0, 2'b11, TOP_BIT, TOP_BIT, 1'b0, 1'b0);
		add_row(1'b0, 2'b00, TOP_BIT, TOP_BIT, 1'b0, 1'b0);
		add_row(1'b0, 2'b01, '1, '1, 1'b0, 1'b0);
		add_row(1'b0, 2'b10, TOP_BIT, '1, 1'b0, 1'b0);
		add_row(1'b0, 2'b11, TOP_BIT, 64'h7fff_ffff_ffff_ffff, 1'b0, 1'b0);
		add_row(1'b0, 2'b00, '0, '1, 1'b0, 1'b0);
		add_row(1'b0, 2'b01, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 1'b1, 1'b0);
		// word mode, junk in the upper halves
		add_row(1'b1, 2'b11, 64'hdead_beef_8000_0000, 64'h1234_5678_0000_0002, 1'b0, 1'b0);
		add_row(1'b1, 2'b00, '1, '1, 1'b0, 1'b0);
		add_row(1'b1, 2'b11, 64'hffff_0000_7fff_ffff, 64'h0000_ffff_7fff_ffff, 1'b0, 1'b0);
		add_row(1'b1, 2'b01, 64'h5555_5555_ffff_fffe, 64'haaaa_aaaa_ffff_ffff, 1'b0, 1'b0);
		add_row(1'b1, 2'b10, 64'h0000_0001_8000_0000, 64'h7777_0000_ffff_fff0, 1'b0, 1'b0);
		// flush right behind two operations, then one more
		add_row(1'b0, 2'b11, 64'h1111_2222_3333_4444, 64'hf0f0_0f0f_a5a5_5a5a, 1'b0, 1'b0);
		add_row(1'b0, 2'b00, 64'h9999_8888_7777_6666, 64'h0000_0000_0001_0003, 1'b0, 1'b0);
		add_row(1'b0, 2'b00, '1, '1, 1'b0, 1'b1);
		add_row(1'b0, 2'b10, 64'hcafe_0000_0000_f00d, 64'h8000_0000_0000_0001, 1'b0, 1'b0);
		// flush with an empty pipeline
		add_row(1'b1, 2'b11, 64'h0000_0000_ffff_ffff, 64'h0000_0000_0000_0003, 1'b1, 1'b1);
		add_row(1'b1, 2'b11, 64'h0000_0000_ffff_ffff, 64'h0000_0000_0000_0003, 1'b0, 1'b0);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			word = ($urandom_range(3, 0) == 0);
			sgn  = 2'($urandom_range(3, 0));
			a    = random_operand();
			b    = random_operand();
			gap  = ($urandom_range(3, 0) == 0);
			fl   = ($urandom_range(7, 0) == 0);
			add_row(word, sgn, a, b, gap, fl);
		end
	endtask

	// model of what the outputs must show at each edge
	always @(posedge clk) begin
		expect_t                head;
		logic [2*`MUL_XLEN-1:0] prod;
		if (cyc >= cycle_limit) begin
			abort_run($sformatf("timeout after %0d cycles with results outstanding", cyc));
		end
		// first edge still sees the power-up value
		if (cyc > 0) begin
			if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
				assert (out_valid === 1'b1)
					else abort_run("out_valid did not rise two edges after an accepted operation");
				head = exp_q.pop_front();
				assert (result_hi === head.hi)
					else report_mismatch("result_hi", result_hi, head.hi);
				assert (result_lo === head.lo)
					else report_mismatch("result_lo", result_lo, head.lo);
			end else begin
				assert (out_valid === 1'b0)
					else abort_run("out_valid is high with no operation due this cycle");
			end
		end
		// whatever is still queued sits in a stage that the flush clears
		if (rst_n && flush) begin
			exp_q.delete();
		end
		if (rst_n && mul_valid && !flush) begin
			prod = expected_product(mulw, mul_signed, multiplicand, multiplier);
			head.hi  = prod[2*`MUL_XLEN-1:`MUL_XLEN];
			head.lo  = prod[`MUL_XLEN-1:0];
			head.due = cyc + 2;
			exp_q.push_back(head);
		end
		cyc = cyc + 1;
	end

	initial begin
		int gaps;
		rst_n        = 1'b0;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		mulw         = 1'b0;
		mul_signed   = 2'b00;
		multiplicand = '0;
		multiplier   = '0;
		void'($urandom(SEED));
		build_table();
		gaps = 0;
		foreach (table_q[i]) begin
			if (table_q[i].gap) begin
				gaps++;
			end
		end
		cycle_limit = table_q.size() + gaps + RESET_CYCLES + MARGIN;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		foreach (table_q[i]) begin
			if (table_q[i].gap) begin
				@(posedge clk);
				mul_valid <= 1'b0;
				flush     <= 1'b0;
			end
			@(posedge clk);
			mul_valid    <= 1'b1;
			flush        <= table_q[i].flush;
			mulw         <= table_q[i].mulw;
			mul_signed   <= table_q[i].sgn;
			multiplicand <= table_q[i].a;
			multiplier   <= table_q[i].b;
		end
		@(posedge clk);
		mul_valid <= 1'b0;
		flush     <= 1'b0;

		// the queue is looked at between edges, once the model has seen the last one
		@(negedge clk);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		// a couple of idle edges to catch a stray out_valid
		repeat (2) @(negedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule
